// File: flist.f
+incdir+hw
hw/serdes_test_pkg.sv
hw/prbs_lfsr.sv
hw/word_serializer.sv
hw/bit_comparator.sv
hw/oserdes_test.sv
tests/tb_oserdes_test.sv

// File: hw/bit_comparator.sv
`timescale 1ns/10ps
`include "serdes_test_settings.svh"

module bit_comparator #(
    parameter int ERROR_HOLD = 2500000
) (
    input  logic CLK,
    input  logic RST,
    input  logic ref_bit,
    input  logic ser_in,
    output logic error
);

    localparam int WIN_W  = $clog2(`COMPARE_WINDOW);
    localparam int HOLD_W = $clog2(ERROR_HOLD + 1);

    logic [`MAX_SLIP-2:0]       ref_dly;
    logic [`MAX_SLIP-1:0]       ref_taps;
    serdes_test_pkg::slip_t     slip;
    logic                       ref_sel;
    logic                       mismatch;
    logic [WIN_W-1:0]           win_cnt;
    logic                       win_end;
    serdes_test_pkg::err_count_t err_cnt;
    serdes_test_pkg::err_count_t err_next;
    logic [HOLD_W-1:0]          hold_cnt;

    // ==========================================================
    // Reference delay line
    // ==========================================================

    // Newest bit at index 0
    always_ff @(posedge CLK) begin
        ref_dly <= {ref_dly[`MAX_SLIP-3:0], ref_bit};
    end

    // Tap 0 is the undelayed reference
    assign ref_taps = {ref_dly, ref_bit};
    assign ref_sel  = ref_taps[slip];
    assign mismatch = ref_sel ^ ser_in;

    // ==========================================================
    // Window and slip search
    // ==========================================================

    assign win_end  = (win_cnt == WIN_W'(`COMPARE_WINDOW - 1));
    assign err_next = err_cnt + serdes_test_pkg::err_count_t'(mismatch);

    // Too many errors in a window means wrong alignment
    // Try the next delay, wrap after the last one
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            win_cnt <= '0;
            err_cnt <= '0;
            slip    <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            if (win_end) begin
                err_cnt <= '0;
                if (err_next >= serdes_test_pkg::err_count_t'(`ERROR_COUNT)) begin
                    if (slip == serdes_test_pkg::slip_t'(`MAX_SLIP - 1)) begin
                        slip <= '0;
                    end else begin
                        slip <= slip + 1'b1;
                    end
                end
            end else begin
                err_cnt <= err_next;
            end
        end
    end

    // ==========================================================
    // Error flag with hold
    // ==========================================================

    // Any mismatch sets the flag and restarts the hold
    // Falls after ERROR_HOLD clean cycles in a row
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            hold_cnt <= '0;
            error    <= 1'b0;
        end else if (mismatch) begin
            hold_cnt <= HOLD_W'(ERROR_HOLD);
            error    <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
            if (hold_cnt == HOLD_W'(1)) begin
                error <= 1'b0;
            end
        end
    end

endmodule

// File: hw/oserdes_test.sv
`timescale 1ns/10ps
`include "serdes_test_settings.svh"

module oserdes_test #(
    parameter int ERROR_HOLD = 2500000
) (
    input  logic CLK,
    input  logic CLKDIV,
    input  logic RST,
    input  logic ser_in,
    output logic ser_out,
    output logic error
);

    // Cycles of suppressed comparison after reset
    localparam int FILL_CYCLES = 2 * `SER_WIDTH;
    localparam int FILL_W      = $clog2(FILL_CYCLES + 1);

    logic                       clkdiv_q;
    logic                       frame_ce;
    serdes_test_pkg::ser_word_t word;
    serdes_test_pkg::ser_word_t ref_sr;
    logic                       ref_bit;
    logic [FILL_W-1:0]          fill_cnt;
    logic                       filling;
    logic                       cmp_ref;

    // ==========================================================
    // Frame strobe
    // ==========================================================

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            clkdiv_q <= 1'b0;
        end else begin
            clkdiv_q <= CLKDIV;
        end
    end

    // One CLK pulse after each CLKDIV fall
    assign frame_ce = clkdiv_q & ~CLKDIV;

    // ==========================================================
    // Data source and serializer
    // ==========================================================

    prbs_lfsr u_lfsr (
        .CLK  (CLK),
        .RST  (RST),
        .ce   (frame_ce),
        .word (word)
    );

    word_serializer u_serializer (
        .CLK     (CLK),
        .CLKDIV  (CLKDIV),
        .RST     (RST),
        .word    (word),
        .ser_out (ser_out)
    );

    // ==========================================================
    // Reference shifter
    // ==========================================================

    // Same frame as the serializer, LSB first
    // Alignment to the pin is left to the comparator
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            ref_sr <= '0;
        end else if (frame_ce) begin
            ref_sr <= word;
        end else begin
            ref_sr <= ref_sr >> 1;
        end
    end

    assign ref_bit = ref_sr[0];

    // Post-reset fill counter
    // Saturates once the pipeline is full
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            fill_cnt <= '0;
        end else if (filling) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign filling = (fill_cnt != FILL_W'(FILL_CYCLES));

    // Reference follows the pin while filling, so nothing mismatches
    assign cmp_ref = filling ? ser_in : ref_bit;

    // ==========================================================
    // Comparator
    // ==========================================================

    bit_comparator #(
        .ERROR_HOLD (ERROR_HOLD)
    ) u_comparator (
        .CLK     (CLK),
        .RST     (RST),
        .ref_bit (cmp_ref),
        .ser_in  (ser_in),
        .error   (error)
    );

endmodule

// File: hw/prbs_lfsr.sv
`timescale 1ns/10ps
`include "serdes_test_settings.svh"

module prbs_lfsr (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       ce,
    output serdes_test_pkg::ser_word_t word
);

    // Start state, never all zeros
    localparam logic [15:0] SEED = 16'hACE1;

    logic [15:0] lfsr_q;
    logic        feedback;

    // ==========================================================
    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    // ==========================================================

    // Taps 16, 14, 13, 11 counted from one
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    // One step per frame strobe
    // Feedback enters at bit 0, older bits move up
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            lfsr_q <= SEED;
        end else if (ce) begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // Low bits form the frame
    assign word = lfsr_q[`SER_WIDTH-1:0];

endmodule

// File: hw/serdes_test_pkg.sv
`include "serdes_test_settings.svh"

// ==========================================================
// Shared types for the self-test blocks
// ==========================================================

package serdes_test_pkg;

    // One frame on the serial pin
    typedef logic [`SER_WIDTH-1:0] ser_word_t;

    // Mismatch count, must reach a full window of errors
    typedef logic [$clog2(`COMPARE_WINDOW + 1)-1:0] err_count_t;

    // Reference delay index into the slip line
    typedef logic [$clog2(`MAX_SLIP)-1:0] slip_t;

endpackage

// File: hw/serdes_test_settings.svh
`ifndef SERDES_TEST_SETTINGS_SVH
`define SERDES_TEST_SETTINGS_SVH

// ==========================================================
// Serial link self-test settings
// ==========================================================

// Bits per frame, shifted out LSB first
`define SER_WIDTH 8

// Mismatches in one window that force a bit slip
`define ERROR_COUNT 16

// Compared bits per window
`define COMPARE_WINDOW 64

// Reference delay positions searched before wrapping to 0
`define MAX_SLIP 32

`endif

// File: hw/word_serializer.sv
`timescale 1ns/10ps

module word_serializer (
    input  logic                      CLK,
    input  logic                      CLKDIV,
    input  logic                      RST,
    input  serdes_test_pkg::ser_word_t word,
    output logic                      ser_out
);

    // Reset sequencer length in CLKDIV cycles
    localparam int SEQ_LEN = 4;

    serdes_test_pkg::ser_word_t cap_word;
    serdes_test_pkg::ser_word_t shift_q;
    logic [SEQ_LEN-1:0]         seq_q;
    logic                       seq_busy;
    logic                       clkdiv_q;
    logic                       div_rise;

    // ==========================================================
    // CLKDIV domain
    // ==========================================================

    // Parallel capture of the frame
    always_ff @(posedge CLKDIV) begin
        cap_word <= word;
    end

    // Reset sequencer
    // All ones on RST, drains one bit per CLKDIV edge
    always_ff @(posedge CLKDIV or posedge RST) begin
        if (RST) begin
            seq_q <= '1;
        end else begin
            seq_q <= seq_q >> 1;
        end
    end

    // Busy until the last one has shifted out
    assign seq_busy = seq_q[0];

    // ==========================================================
    // CLK domain
    // ==========================================================

    // CLKDIV as seen one CLK later
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            clkdiv_q <= 1'b0;
        end else begin
            clkdiv_q <= CLKDIV;
        end
    end

    // High on the CLK edge after a CLKDIV rise
    assign div_rise = CLKDIV & ~clkdiv_q;

    // Shift register
    // Held at zero while the sequencer is busy
    // Loads the captured frame, then drops one bit per CLK
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            shift_q <= '0;
        end else if (seq_busy) begin
            shift_q <= '0;
        end else if (div_rise) begin
            shift_q <= cap_word;
        end else begin
            shift_q <= shift_q >> 1;
        end
    end

    // LSB goes out first
    assign ser_out = shift_q[0];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the loopback self-test with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_oserdes_test -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
    && echo "Simulation run: pass" \
    || { echo "Simulation run: fail"; exit 1; }

// File: tests/tb_oserdes_test.sv
`timescale 1ns/10ps
`include "serdes_test_settings.svh"

module tb_oserdes_test;

    localparam int ERROR_HOLD     = 64;
    localparam int REC_LEN        = 800;
    localparam int SEARCH_MAX     = 200;
    localparam int START_BYTES    = 16;
    localparam int CHECK_BYTES    = 64;
    localparam int RELOCK_TIMEOUT = `MAX_SLIP * `COMPARE_WINDOW * 2;
    localparam int QUIET_CYCLES   = 256;
    localparam int STABLE_CYCLES  = 2000;

    logic CLK;
    logic CLKDIV;
    logic RST;
    logic ser_in;
    logic ser_out;
    logic error;

    int          div_cnt;
    logic [31:0] hist;
    int          delay;
    logic        flip_next;
    logic        rec_bits [0:REC_LEN-1];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_start;
    int          old_delay;
    int          wait_n;
    int          high;
    int          i;
    serdes_test_pkg::ser_word_t model_bytes [0:START_BYTES+CHECK_BYTES-1];

    oserdes_test #(
        .ERROR_HOLD (ERROR_HOLD)
    ) dut_i (
        .CLK     (CLK),
        .CLKDIV  (CLKDIV),
        .RST     (RST),
        .ser_in  (ser_in),
        .ser_out (ser_out),
        .error   (error)
    );

    // ==========================================================
    // Clocks and loopback channel
    // ==========================================================

    always #4 CLK = ~CLK;

    // CLKDIV at CLK/8, moved just after the CLK rise
    always @(posedge CLK) begin
        #1;
        if (div_cnt == 3) begin
            div_cnt = 0;
            CLKDIV  = ~CLKDIV;
        end else begin
            div_cnt = div_cnt + 1;
        end
    end

    // One CLK step; pin history shifts in, delayed tap drives ser_in
    // Optional one-shot inversion on the driven bit only
    task automatic tick();
        @(posedge CLK);
        #1;
        hist      = {hist[30:0], ser_out};
        ser_in    = hist[delay] ^ flip_next;
        flip_next = 1'b0;
    endtask

    // ==========================================================
    // Reference model and checks
    // ==========================================================

    // x^16 + x^14 + x^13 + x^11 + 1, new bit at bit 0
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic build_model();
        logic [15:0] s;
        int k;
        s = 16'hACE1;
        for (k = 0; k < START_BYTES + CHECK_BYTES; k++) begin
            model_bytes[k] = s[`SER_WIDTH-1:0];
            s = lfsr_next(s);
        end
    endtask

    // Recorded pin bits p.. rebuilt LSB first
    function automatic serdes_test_pkg::ser_word_t byte_at(input int p);
        serdes_test_pkg::ser_word_t b;
        int k;
        for (k = 0; k < `SER_WIDTH; k++) begin
            b[k] = rec_bits[p + k];
        end
        return b;
    endfunction

    function automatic logic bytes_match(input int p, input int j, input int n);
        int k;
        for (k = 0; k < n; k++) begin
            if (byte_at(p + k * `SER_WIDTH) != model_bytes[j + k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Reset held 16 cycles, outputs quiet through sequencer and fill
    task automatic apply_reset();
        int k;
        RST = 1'b1;
        for (k = 0; k < 16; k++) begin
            tick();
            if (ser_out !== 1'b0 || error !== 1'b0) begin
                $display("Fail at %0t: ser_out %b error %b during reset", $time, ser_out, error);
                errors++;
            end
        end
        RST = 1'b0;
        for (k = 0; k < 24; k++) begin
            tick();
            if (ser_out !== 1'b0) begin
                $display("Fail at %0t: ser_out %b before sequencer release", $time, ser_out);
                errors++;
            end
            if (k < 16 && error !== 1'b0) begin
                $display("Fail at %0t: error raised during pipeline fill", $time);
                errors++;
            end
        end
    endtask

    // Capture the pin, align on three model bytes, then check 64 in order
    task automatic check_stream();
        int p;
        int j;
        int p0;
        int j0;
        int k;
        logic found;
        for (k = 0; k < REC_LEN; k++) begin
            tick();
            rec_bits[k] = ser_out;
        end
        found = 1'b0;
        p0    = 0;
        j0    = 0;
        for (p = 0; p < SEARCH_MAX && !found; p++) begin
            for (j = 0; j < START_BYTES && !found; j++) begin
                if (bytes_match(p, j, 3)) begin
                    found = 1'b1;
                    p0    = p;
                    j0    = j;
                end
            end
        end
        if (!found) begin
            $display("No LFSR byte sequence found on ser_out after reset");
            errors++;
        end else begin
            for (k = 0; k < CHECK_BYTES; k++) begin
                if (byte_at(p0 + k * `SER_WIDTH) != model_bytes[j0 + k]) begin
                    $display("Fail at %0t: byte %0d is %h, expected %h", $time, k,
                             byte_at(p0 + k * `SER_WIDTH), model_bytes[j0 + k]);
                    errors++;
                    break;
                end
            end
        end
    endtask

    // Settled once error has stayed low for a run of cycles
    task automatic wait_quiet();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES && waited < RELOCK_TIMEOUT) begin
            tick();
            waited++;
            quiet = error ? 0 : quiet + 1;
        end
        if (quiet < QUIET_CYCLES) begin
            $display("Timeout: error flag did not settle within %0d cycles", RELOCK_TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_stable(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            tick();
            if (error) begin
                $display("Fail at %0t: error set while the link is locked", $time);
                errors++;
                break;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errors - start);
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        CLK       = 1'b0;
        CLKDIV    = 1'b0;
        RST       = 1'b1;
        ser_in    = 1'b0;
        hist      = '0;
        flip_next = 1'b0;
        div_cnt   = 0;
        errors    = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'hb694f6ac));
        build_model();
        // Pin leads the reference by 4 CLK, slips past 8 alias onto the shifted stream
        delay = 6 + int'($urandom % 4);

        err_start = errors;
        apply_reset();
        report_test(1, "reset quiet", err_start);

        err_start = errors;
        check_stream();
        report_test(2, "byte stream", err_start);

        err_start = errors;
        wait_quiet();
        check_stable(STABLE_CYCLES);
        report_test(3, "slip lock", err_start);

        // Single flipped bit, flag held for ERROR_HOLD cycles
        err_start = errors;
        wait_n = int'($urandom % 64);
        repeat (wait_n) tick();
        flip_next = 1'b1;
        tick();
        high = 0;
        for (i = 0; i < 3 && high == 0; i++) begin
            tick();
            if (error) high = 1;
        end
        if (high == 0) begin
            $display("Fail at %0t: flipped bit did not raise error", $time);
            errors++;
        end else begin
            while (error && high <= ERROR_HOLD + 8) begin
                tick();
                if (error) high++;
            end
            if (high < ERROR_HOLD || high > ERROR_HOLD + 3) begin
                $display("Fail at %0t: error held %0d cycles", $time, high);
                errors++;
            end
            check_stable(STABLE_CYCLES);
        end
        report_test(4, "bit flip", err_start);

        // Longer delay, so the search moves up to the new alignment
        err_start = errors;
        old_delay = delay;
        delay = old_delay + 1 + int'($urandom % (12 - old_delay));
        for (i = 0; i < 64 && !error; i++) tick();
        if (!error) begin
            $display("Fail at %0t: delay change %0d to %0d left error low", $time,
                     old_delay, delay);
            errors++;
        end
        wait_quiet();
        report_test(5, "delay change", err_start);

        // Flipped bit first, so the reset has a raised flag to clear
        err_start = errors;
        flip_next = 1'b1;
        tick();
        high = 0;
        for (i = 0; i < 3 && high == 0; i++) begin
            tick();
            if (error) high = 1;
        end
        if (high == 0) begin
            $display("Fail at %0t: flipped bit before reset did not raise error", $time);
            errors++;
        end
        // Asynchronous reset clears the pins at once
        RST = 1'b1;
        #1;
        if (ser_out !== 1'b0 || error !== 1'b0) begin
            $display("Fail at %0t: outputs not cleared by RST", $time);
            errors++;
        end
        apply_reset();
        check_stream();
        report_test(6, "mid-run reset", err_start);

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
